// ==== tile_display.f ====
+incdir+bench
src/video_pkg.sv
src/video_driver.sv
src/tile_renderer.sv
src/tile_ram.sv
src/tile_display_top.sv
bench/tile_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tile display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tile_display_tb \
    -f tile_display.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtile_display_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "simulation reported failure"
exit 1

// ==== bench/tile_display_cases.svh ====
localparam int N_TILES = 6;

// RGB565 colour of each tile in row-major order
localparam logic [RGB565_W-1:0] TILE_INIT [N_TILES] = '{
    16'hF800, 16'h07E0, 16'h001F,   // top row red green blue
    16'hFFFF, 16'h8410, 16'h4208    // bottom row white and two greys
};

// tile rewritten in the first vertical blanking
localparam int                  REWR_TILE = 4;
localparam logic [RGB565_W-1:0] REWR_DATA = 16'hFFE0;

//****************************************
// pixel probes
//****************************************

localparam int N_PROBES = 13;

// active x and y of each probe with its expected tile or -1 for the background
localparam int PROBE_X    [N_PROBES] = '{8, 23, 24, 55,  8, 24, 30, 40,  7, 56, 20,  0, 63};
localparam int PROBE_Y    [N_PROBES] = '{8,  8,  8, 23, 24, 24, 30, 39,  8, 20, 40,  0, 47};
localparam int PROBE_TILE [N_PROBES] = '{0,  0,  1,  2,  3,  4,  4,  5, -1, -1, -1, -1, -1};

// ==== bench/tile_display_tb.sv ====
`timescale 1ns/10ps

module tile_display_tb;

    import video_pkg::*;

    // small raster of 96 counts by 56 lines
    localparam int H_SYNC  = 16;
    localparam int H_BACK  = 8;
    localparam int H_DISP  = 64;
    localparam int H_FRONT = 8;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 4;
    localparam int V_DISP  = 48;
    localparam int V_FRONT = 2;
    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;
    localparam int TIMEOUT = 2 * H_TOTAL * V_TOTAL + 200;  // two frames plus slack

    `include "tile_display_cases.svh"

    logic                pixel_clk;
    logic                sys_rst_n;
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    logic [RGB565_W-1:0] wr_data;
    logic                video_hs;
    logic                video_vs;
    logic                video_de;
    logic [RGB888_W-1:0] video_rgb;

    int    k = 0;               // samples since reset release
    int    cycles = 0;
    int    h;
    int    v;
    int    t;
    int    px = 0;              // de-high cycles in this line
    int    py = 0;              // de lines in this frame
    int    frame = 0;
    int    probes_seen = 0;
    int    total = 0;
    logic  prev_vs = 1'b0;
    int    errs [6] = '{default: 0};
    string test_name [6] = '{"reset and first sync", "sync period", "de counts and blanking",
                             "window tiles", "background", "tile rewrite"};

    tile_display_top #(
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .H_DISP    (H_DISP),
        .H_FRONT   (H_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK),
        .V_DISP    (V_DISP),
        .V_FRONT   (V_FRONT),
        .GAME_X0   (8),
        .GAME_Y0   (8),
        .TILE_COLS (3),
        .TILE_ROWS (2)
    ) tile_display_top_i (.*);

    always #4 pixel_clk = ~pixel_clk;

    //****************************************
    // helpers
    //****************************************

    task automatic compare_value(input int tn, input string name,
                                 input logic [RGB888_W-1:0] got, input logic [RGB888_W-1:0] exp);
        assert (got === exp) else begin
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
            errs[tn]++;
        end
    endtask

    // each RGB565 channel moved to the top of its 8-bit lane
    function automatic logic [RGB888_W-1:0] expect_rgb(input int tile, input int frm);
        logic [RGB565_W-1:0] c;
        int                  r;
        int                  g;
        int                  b;
        if (tile < 0) begin
            return BG_RGB;
        end
        c = (frm > 0 && tile == REWR_TILE) ? REWR_DATA : TILE_INIT[tile];
        r = int'(c) / 2048;
        g = (int'(c) / 32) % 64;
        b = int'(c) % 32;
        return RGB888_W'((r * 8) * 65536 + (g * 4) * 256 + b * 8);
    endfunction

    task automatic check_probes(input int x, input int y);
        for (int i = 0; i < N_PROBES; i++) begin
            if (PROBE_X[i] == x && PROBE_Y[i] == y && frame < 2) begin
                probes_seen++;
                t = (frame > 0) ? 5 : ((PROBE_TILE[i] < 0) ? 4 : 3);
                compare_value(t, "video_rgb", video_rgb, expect_rgb(PROBE_TILE[i], frame));
            end
        end
    endtask

    task automatic write_tile(input int addr, input logic [RGB565_W-1:0] data);
        wr_en   = 1'b1;
        wr_addr = ADDR_W'(addr);
        wr_data = data;
        @(posedge pixel_clk);
        #1 wr_en = 1'b0;
    endtask

    task automatic report_test(input int tn);
        $display("test %0d %s: %s, %0d errors", tn + 1, test_name[tn],
                 (errs[tn] == 0) ? "pass" : "fail", errs[tn]);
    endtask

    //****************************************
    // raster model and tracking
    //****************************************

    always @(negedge pixel_clk) begin
        if (sys_rst_n) begin
            h = k % H_TOTAL;
            v = (k / H_TOTAL) % V_TOTAL;
            t = (k <= V_SYNC * H_TOTAL) ? 0 : 1;
            compare_value(t, "video_hs", 24'(video_hs), 24'(h >= H_SYNC));
            compare_value(t, "video_vs", 24'(video_vs), 24'(v >= V_SYNC));
            t = (k <= V_SYNC * H_TOTAL) ? 0 : 2;
            compare_value(t, "video_de", 24'(video_de),
                          24'(h >= H_SYNC + H_BACK && h < H_SYNC + H_BACK + H_DISP
                              && v >= V_SYNC + V_BACK && v < V_SYNC + V_BACK + V_DISP));
            if (video_de) begin
                check_probes(px, py);
                px++;
            end else begin
                compare_value(t, "video_rgb", video_rgb, '0);  // black in blanking
                if (px != 0) begin
                    compare_value(2, "de cycles per line", 24'(px), 24'(H_DISP));
                    px = 0;
                    py++;
                end
            end
            if (prev_vs && !video_vs) begin    // new frame
                compare_value(2, "de lines per frame", 24'(py), 24'(V_DISP));
                py = 0;
                frame++;
            end
            prev_vs = video_vs;
            k++;
        end
    end

    always @(posedge pixel_clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: the raster did not finish two frames in %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $finish;
        end
    end

    //****************************************
    // main sequence
    //****************************************

    initial begin
        pixel_clk = 1'b0;
        sys_rst_n = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        repeat (8) @(posedge pixel_clk);
        #1 sys_rst_n = 1'b1;
        for (int i = 0; i < N_TILES; i++) begin   // fill during the first blanking
            write_tile(i, TILE_INIT[i]);
        end
        wait (k > V_SYNC * H_TOTAL);
        report_test(0);
        wait (frame == 0 && v >= V_SYNC + V_BACK + V_DISP);  // vertical front porch of frame 0
        @(posedge pixel_clk);
        #1;
        write_tile(REWR_TILE, REWR_DATA);
        compare_value(3, "probe hits", 24'(probes_seen), 24'(N_PROBES));
        report_test(3);
        report_test(4);
        wait (frame == 2);
        compare_value(5, "probe hits", 24'(probes_seen), 24'(2 * N_PROBES));
        report_test(1);
        report_test(2);
        report_test(5);
        foreach (errs[i]) begin
            total += errs[i];
        end
        $display("tests 6, errors %0d, probes seen %0d", total, probes_seen);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src/tile_display_top.sv ====
`timescale 1ns/10ps

module tile_display_top #(
    // 640x480 at 60 Hz
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int H_DISP    = 640,
    parameter int H_FRONT   = 16,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int V_DISP    = 480,
    parameter int V_FRONT   = 10,

    // game window, centred 320x192
    parameter int GAME_X0   = 160,
    parameter int GAME_Y0   = 144,
    parameter int TILE_COLS = 20,
    parameter int TILE_ROWS = 12
) (
    input  logic                          pixel_clk,
    input  logic                          sys_rst_n,

    // host tile writes
    input  logic                          wr_en,
    input  logic [video_pkg::ADDR_W-1:0]   wr_addr,
    input  logic [video_pkg::RGB565_W-1:0] wr_data,

    // video out
    output logic                          video_hs,
    output logic                          video_vs,
    output logic                          video_de,
    output logic [video_pkg::RGB888_W-1:0] video_rgb
);

    import video_pkg::*;

    logic [COORD_W-1:0]  pixel_xpos;
    logic [COORD_W-1:0]  pixel_ypos;
    logic                pixel_req;
    logic [ADDR_W-1:0]   rd_addr;
    logic [RGB565_W-1:0] rd_data;
    logic                game_window;

    //****************************************
    // raster and output stage
    //****************************************

    video_driver #(
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_DISP  (H_DISP),
        .H_FRONT (H_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_DISP  (V_DISP),
        .V_FRONT (V_FRONT)
    ) video_driver_i (
        .pixel_clk     (pixel_clk),
        .sys_rst_n     (sys_rst_n),
        .pixel_xpos    (pixel_xpos),
        .pixel_ypos    (pixel_ypos),
        .pixel_req     (pixel_req),
        .video_rgb_565 (rd_data),
        .game_window   (game_window),
        .video_hs      (video_hs),
        .video_vs      (video_vs),
        .video_de      (video_de),
        .video_rgb     (video_rgb)
    );

    //****************************************
    // tile lookup
    //****************************************

    tile_renderer #(
        .GAME_X0   (GAME_X0),
        .GAME_Y0   (GAME_Y0),
        .TILE_COLS (TILE_COLS),
        .TILE_ROWS (TILE_ROWS)
    ) tile_renderer_i (
        .pixel_clk   (pixel_clk),
        .sys_rst_n   (sys_rst_n),
        .pixel_xpos  (pixel_xpos),
        .pixel_ypos  (pixel_ypos),
        .pixel_req   (pixel_req),
        .rd_addr     (rd_addr),
        .game_window (game_window)
    );

    tile_ram #(
        .DEPTH (TILE_COLS * TILE_ROWS)  // one word per tile
    ) tile_ram_i (
        .pixel_clk (pixel_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

// ==== src/tile_ram.sv ====
`timescale 1ns/10ps

module tile_ram #(
    parameter int DEPTH = 240       // tiles in the map
) (
    input  logic                          pixel_clk,

    // host write port
    input  logic                          wr_en,
    input  logic [video_pkg::ADDR_W-1:0]   wr_addr,
    input  logic [video_pkg::RGB565_W-1:0] wr_data,

    // renderer read port
    input  logic [video_pkg::ADDR_W-1:0]   rd_addr,
    output logic [video_pkg::RGB565_W-1:0] rd_data
);

    import video_pkg::*;

    localparam int                AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [ADDR_W-1:0] LAST = ADDR_W'(DEPTH - 1);

    logic [RGB565_W-1:0] mem [DEPTH];

    // writes past the map are dropped
    always_ff @(posedge pixel_clk) begin
        if (wr_en && (wr_addr <= LAST)) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge pixel_clk) begin
        rd_data <= mem[rd_addr[AW-1:0]];
    end

endmodule

// ==== src/tile_renderer.sv ====
`timescale 1ns/10ps

module tile_renderer #(
    parameter int GAME_X0   = 160,  // left edge of the game window
    parameter int GAME_Y0   = 112,  // top edge of the game window
    parameter int TILE_COLS = 20,
    parameter int TILE_ROWS = 12
) (
    input  logic                         pixel_clk,
    input  logic                         sys_rst_n,

    input  logic [video_pkg::COORD_W-1:0] pixel_xpos,
    input  logic [video_pkg::COORD_W-1:0] pixel_ypos,
    input  logic                         pixel_req,

    output logic [video_pkg::ADDR_W-1:0]  rd_addr,
    output logic                         game_window
);

    import video_pkg::*;

    // window bounds, end exclusive
    localparam logic [COORD_W-1:0] X0_C = COORD_W'(GAME_X0);
    localparam logic [COORD_W-1:0] Y0_C = COORD_W'(GAME_Y0);
    localparam logic [COORD_W-1:0] X1_C = COORD_W'(GAME_X0 + (TILE_COLS << TILE_SHIFT));
    localparam logic [COORD_W-1:0] Y1_C = COORD_W'(GAME_Y0 + (TILE_ROWS << TILE_SHIFT));
    localparam logic [COORD_W-1:0] COLS_C = COORD_W'(TILE_COLS);

    logic               in_window;
    logic [COORD_W-1:0] off_x;
    logic [COORD_W-1:0] off_y;
    logic [COORD_W-1:0] tile_col;
    logic [COORD_W-1:0] tile_row;
    logic [COORD_W-1:0] tile_idx;

    //****************************************
    // window test and tile index
    //****************************************

    assign in_window = pixel_req
                    && (pixel_xpos >= X0_C) && (pixel_xpos < X1_C)
                    && (pixel_ypos >= Y0_C) && (pixel_ypos < Y1_C);

    // offsets inside the window
    assign off_x = pixel_xpos - X0_C;
    assign off_y = pixel_ypos - Y0_C;

    assign tile_col = off_x >> TILE_SHIFT;
    assign tile_row = off_y >> TILE_SHIFT;

    // row-major index into the tile map
    assign tile_idx = tile_row * COLS_C + tile_col;

    assign rd_addr = in_window ? tile_idx[ADDR_W-1:0] : '0;

    //****************************************
    // window flag, lines up with ram data
    //****************************************

    always_ff @(posedge pixel_clk) begin
        if (!sys_rst_n) begin
            game_window <= 1'b0;
        end else begin
            game_window <= in_window;
        end
    end

endmodule

// ==== src/video_driver.sv ====
`timescale 1ns/10ps

module video_driver #(
    parameter int H_SYNC  = 96,     // line sync width
    parameter int H_BACK  = 48,     // line back porch
    parameter int H_DISP  = 640,    // active pixels per line
    parameter int H_FRONT = 16,     // line front porch
    parameter int V_SYNC  = 2,      // frame sync lines
    parameter int V_BACK  = 33,     // frame back porch
    parameter int V_DISP  = 480,    // active lines per frame
    parameter int V_FRONT = 10      // frame front porch
) (
    input  logic                          pixel_clk,
    input  logic                          sys_rst_n,

    // pixel request towards the renderer
    output logic [video_pkg::COORD_W-1:0]  pixel_xpos,
    output logic [video_pkg::COORD_W-1:0]  pixel_ypos,
    output logic                          pixel_req,

    // pixel data back from the tile path
    input  logic [video_pkg::RGB565_W-1:0] video_rgb_565,
    input  logic                          game_window,

    // video output
    output logic                          video_hs,
    output logic                          video_vs,
    output logic                          video_de,
    output logic [video_pkg::RGB888_W-1:0] video_rgb
);

    import video_pkg::*;

    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    // count values for the decodes, all at counter width
    localparam logic [COORD_W-1:0] H_LAST   = COORD_W'(H_TOTAL - 1);
    localparam logic [COORD_W-1:0] V_LAST   = COORD_W'(V_TOTAL - 1);
    localparam logic [COORD_W-1:0] H_SYNC_C = COORD_W'(H_SYNC);
    localparam logic [COORD_W-1:0] V_SYNC_C = COORD_W'(V_SYNC);
    localparam logic [COORD_W-1:0] H_ACT0   = COORD_W'(H_SYNC + H_BACK);
    localparam logic [COORD_W-1:0] H_ACT1   = COORD_W'(H_SYNC + H_BACK + H_DISP);
    localparam logic [COORD_W-1:0] H_REQ0   = COORD_W'(H_SYNC + H_BACK - 1);
    localparam logic [COORD_W-1:0] H_REQ1   = COORD_W'(H_SYNC + H_BACK + H_DISP - 1);
    localparam logic [COORD_W-1:0] V_ACT0   = COORD_W'(V_SYNC + V_BACK);
    localparam logic [COORD_W-1:0] V_ACT1   = COORD_W'(V_SYNC + V_BACK + V_DISP);

    logic [COORD_W-1:0]  cnt_h;
    logic [COORD_W-1:0]  cnt_v;
    logic                v_active;
    logic [RGB888_W-1:0] pixel_data;

    //****************************************
    // raster counters
    //****************************************

    always_ff @(posedge pixel_clk) begin
        if (!sys_rst_n) begin
            cnt_h <= '0;
        end else if (cnt_h == H_LAST) begin
            cnt_h <= '0;
        end else begin
            cnt_h <= cnt_h + 1'b1;
        end
    end

    // one step per completed line
    always_ff @(posedge pixel_clk) begin
        if (!sys_rst_n) begin
            cnt_v <= '0;
        end else if (cnt_h == H_LAST) begin
            if (cnt_v == V_LAST) begin
                cnt_v <= '0;
            end else begin
                cnt_v <= cnt_v + 1'b1;
            end
        end
    end

    //****************************************
    // sync, enable and request decode
    //****************************************

    assign video_hs = (cnt_h >= H_SYNC_C);  // active low sync
    assign video_vs = (cnt_v >= V_SYNC_C);

    assign v_active = (cnt_v >= V_ACT0) && (cnt_v < V_ACT1);

    assign video_de  = v_active && (cnt_h >= H_ACT0) && (cnt_h < H_ACT1);
    assign pixel_req = v_active && (cnt_h >= H_REQ0) && (cnt_h < H_REQ1);  // one ahead of de

    // zero-based coordinates of the pixel shown next cycle
    assign pixel_xpos = pixel_req ? (cnt_h - H_REQ0) : '0;
    assign pixel_ypos = pixel_req ? (cnt_v - V_ACT0) : '0;

    //****************************************
    // colour output
    //****************************************

    // low bits of each channel padded with zeros
    assign pixel_data = {video_rgb_565[15:11], 3'b000,
                         video_rgb_565[10:5],  2'b00,
                         video_rgb_565[4:0],   3'b000};

    always_comb begin
        if (!video_de) begin
            video_rgb = '0;             // black in blanking
        end else if (game_window) begin
            video_rgb = pixel_data;
        end else begin
            video_rgb = BG_RGB;
        end
    end

endmodule

// ==== src/video_pkg.sv ====
package video_pkg;

    //****************************************
    // widths
    //****************************************

    // raster counters and pixel coordinates
    localparam int COORD_W  = 12;

    // stored tile colour, 5:6:5
    localparam int RGB565_W = 16;

    // colour on the video output, 8:8:8
    localparam int RGB888_W = 24;

    // tile address, up to 256 tiles
    localparam int ADDR_W   = 8;

    //****************************************
    // tile geometry
    //****************************************

    // log2 of the tile edge, 16x16 pixels
    localparam int TILE_SHIFT = 4;

    //****************************************
    // colours
    //****************************************

    // dark green border around the game window
    localparam logic [RGB888_W-1:0] BG_RGB = 24'h002010;

endpackage
